// ==== verilog/cart_pkg.sv ====
package cart_pkg;

	////////////////////////////////////////
	// Bus and memory widths
	////////////////////////////////////////

	typedef logic [15:0] data_t;       // Bus or download data word
	typedef logic [23:1] bus_addr_t;   // Console word address
	typedef logic [24:0] load_addr_t;  // Download byte address
	typedef logic [23:0] mem_addr_t;   // Shared memory word address

	// Bank registers
	localparam int BANK_COUNT = 8;

	typedef logic [4:0] bank_t;
	typedef bank_t [BANK_COUNT-1:0] bank_table_t;  // Indexed by bus_va[21:19]

	// ROM size mask, one bit per 8 KB block and up
	typedef logic [23:13] rom_mask_t;

	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_t;

	////////////////////////////////////////
	// Address map
	////////////////////////////////////////

	// Region letter inside the cartridge header
	localparam load_addr_t HEADER_REGION_ADDR = 25'h1F0;

	// Shared memory window prefixes
	localparam logic [8:0] WORK_RAM_BASE  = 9'b010000000;  // 800000-80FFFF
	localparam logic [4:0] CART_RAM_BASE  = 5'b01110;      // E00000-EFFFFF
	localparam logic [1:0] CART_ROM_BASE  = 2'b00;         // 000000-7FFFFF
	localparam logic [7:0] BIOS_BASE      = 8'b01111000;   // F00000-F1FFFF
	localparam logic [5:0] BIOS_LOAD_BASE = 6'b011110;     // F00000-F7FFFF

	// Header letters
	localparam logic [7:0] LETTER_J = 8'h4A;
	localparam logic [7:0] LETTER_U = 8'h55;

endpackage

// ==== verilog/rom_header_sniff.sv ====
`timescale 1ns/1ps

module rom_header_sniff
	import cart_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       load_active,
	input  logic       load_is_cart,
	input  logic       load_wr,
	input  load_addr_t load_addr,
	input  data_t      load_data,
	output rom_mask_t  rom_mask,
	output logic       cart_mode,
	output region_t    header_region
);

	logic load_strobe;   // One download word accepted
	logic addr_zero;     // Start of a new image
	logic header_hit;

	assign load_strobe = load_active & load_wr;
	assign addr_zero   = (load_addr == '0);
	assign header_hit  = (load_addr == HEADER_REGION_ADDR);

	////////////////////////////////////////
	// Image kind and size mask
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_mask  <= '0;
			cart_mode <= 1'b0;
		end else if (load_strobe) begin
			cart_mode <= load_is_cart;
			if (load_is_cart) begin
				if (addr_zero)
					rom_mask <= '0;                          // New image, start over
				else
					rom_mask <= rom_mask | load_addr[23:13]; // Grow with highest address
			end
		end
	end

	////////////////////////////////////////
	// Header region letter
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			header_region <= REGION_JP;
		end else if (load_strobe && header_hit) begin
			if (load_data[7:0] == LETTER_J)
				header_region <= REGION_JP;
			else if (load_data[7:0] == LETTER_U)
				header_region <= REGION_US;
			else
				header_region <= REGION_EU;  // Any other letter
		end
	end

endmodule

// ==== verilog/bank_regs.sv ====
`timescale 1ns/1ps

module bank_regs
	import cart_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        load_active,
	input  logic        page_ce_n,
	input  logic        bus_rnw,
	input  bus_addr_t   bus_va,
	input  data_t       bus_vdo,
	input  rom_mask_t   rom_mask,
	output bank_table_t bank_table
);

	// Entry n points at bank n
	localparam bank_table_t IDENTITY_TABLE = {
		5'd7, 5'd6, 5'd5, 5'd4,
		5'd3, 5'd2, 5'd1, 5'd0
	};

	logic       page_ce_n_d;   // Strobe seen on the previous clock
	logic       page_fall;
	logic       large_rom;     // Image beyond 4 MB
	logic [2:0] reg_index;
	logic       reg_write;

	assign page_fall = page_ce_n_d & ~page_ce_n;
	assign large_rom = |rom_mask[23:22];
	assign reg_index = bus_va[3:1];

	// Entry 0 stays fixed, the console never remaps the lowest window
	assign reg_write = page_fall & ~bus_rnw & (reg_index != 3'd0) & large_rom;

	always_ff @(posedge clk_sys) begin
		if (reset)
			page_ce_n_d <= 1'b1;
		else
			page_ce_n_d <= page_ce_n;
	end

	////////////////////////////////////////
	// Bank table
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset || load_active)
			bank_table <= IDENTITY_TABLE;  // Fresh image starts unbanked
		else if (reg_write)
			bank_table[reg_index] <= bus_vdo[4:0];
	end

endmodule

// ==== verilog/mem_addr_route.sv ====
`timescale 1ns/1ps

module mem_addr_route
	import cart_pkg::*;
(
	input  bus_addr_t   bus_va,
	input  bank_table_t bank_table,
	input  rom_mask_t   rom_mask,
	input  logic        work_ram_ce_n,
	input  logic        cart_ram_ce_n,
	input  logic        cart_rom_ce_n,
	input  logic        load_active,
	input  logic        load_is_cart,
	input  load_addr_t  load_addr,
	output mem_addr_t   mem_addr
);

	bank_t     bank_sel;   // Bank for the current 512 KB window
	bus_addr_t rom_va;     // Banked and masked ROM address

	assign bank_sel = bank_table[bus_va[21:19]];

	// Mask wraps reads of a small image onto itself
	assign rom_va = {bank_sel, bus_va[18:1]} & {rom_mask, 12'hFFF};

	////////////////////////////////////////
	// Window select, first match wins
	////////////////////////////////////////

	always_comb begin
		if (load_active) begin
			if (load_is_cart)
				mem_addr = {CART_ROM_BASE, load_addr[22:1]};
			else
				mem_addr = {BIOS_LOAD_BASE, load_addr[18:1]};
		end else if (!work_ram_ce_n) begin
			mem_addr = {WORK_RAM_BASE, bus_va[15:1]};   // 64 KB work RAM
		end else if (!cart_ram_ce_n) begin
			mem_addr = {CART_RAM_BASE, bus_va[19:1]};   // Backup RAM window
		end else if (!cart_rom_ce_n) begin
			mem_addr = {CART_ROM_BASE, rom_va[22:1]};
		end else begin
			mem_addr = {BIOS_BASE, bus_va[16:1]};       // Everything else reads BIOS
		end
	end

endmodule

// ==== verilog/region_select.sv ====
`timescale 1ns/1ps

module region_select
	import cart_pkg::*;
#(
	parameter int SETTLE_CYCLES = 65535
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic [1:0] region_opt,     // 0 follows the header
	input  region_t    header_region,
	output region_t    region,
	output logic       region_set
);

	localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);
	localparam logic [CNT_W-1:0] SETTLE_MAX = CNT_W'(SETTLE_CYCLES);

	region_t          region_new;
	logic [CNT_W-1:0] settle_cnt;

	// Forced choice from the menu, else the header letter
	assign region_new = (region_opt != 2'd0) ? region_t'(region_opt - 2'd1)
	                                         : header_region;

	always_ff @(posedge clk_sys) begin
		if (reset)
			region <= REGION_JP;
		else
			region <= region_new;
	end

	////////////////////////////////////////
	// Settle counter
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset || (region_new != region))
			settle_cnt <= '0;                      // Restart on every change
		else if (settle_cnt < SETTLE_MAX)
			settle_cnt <= settle_cnt + CNT_W'(1);  // Saturates at the end
	end

	// Core is held while the new region settles
	assign region_set = (settle_cnt < SETTLE_MAX);

endmodule

// ==== verilog/cart_glue_top.sv ====
`timescale 1ns/1ps

module cart_glue_top
	import cart_pkg::*;
#(
	parameter int SETTLE_CYCLES = 65535
) (
	input  logic       clk_sys,
	input  logic       reset,

	// ROM download stream
	input  logic       load_active,
	input  logic       load_is_cart,
	input  logic       load_wr,
	input  load_addr_t load_addr,
	input  data_t      load_data,

	// Console bus
	input  bus_addr_t  bus_va,
	input  data_t      bus_vdo,
	input  logic       bus_rnw,
	input  logic       page_ce_n,
	input  logic       work_ram_ce_n,
	input  logic       cart_ram_ce_n,
	input  logic       cart_rom_ce_n,

	input  logic [1:0] region_opt,

	output mem_addr_t  mem_addr,
	output logic       cart_mode,
	output region_t    region,
	output logic       region_set
);

	rom_mask_t   rom_mask;
	region_t     header_region;
	bank_table_t bank_table;

	////////////////////////////////////////
	// Download side
	////////////////////////////////////////

	rom_header_sniff u_sniff (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.load_active   (load_active),
		.load_is_cart  (load_is_cart),
		.load_wr       (load_wr),
		.load_addr     (load_addr),
		.load_data     (load_data),
		.rom_mask      (rom_mask),
		.cart_mode     (cart_mode),
		.header_region (header_region)
	);

	////////////////////////////////////////
	// Mapper and address router
	////////////////////////////////////////

	bank_regs u_banks (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.load_active(load_active),
		.page_ce_n  (page_ce_n),
		.bus_rnw    (bus_rnw),
		.bus_va     (bus_va),
		.bus_vdo    (bus_vdo),
		.rom_mask   (rom_mask),
		.bank_table (bank_table)
	);

	mem_addr_route u_route (
		.bus_va       (bus_va),
		.bank_table   (bank_table),
		.rom_mask     (rom_mask),
		.work_ram_ce_n(work_ram_ce_n),
		.cart_ram_ce_n(cart_ram_ce_n),
		.cart_rom_ce_n(cart_rom_ce_n),
		.load_active  (load_active),
		.load_is_cart (load_is_cart),
		.load_addr    (load_addr),
		.mem_addr     (mem_addr)
	);

	region_select #(
		.SETTLE_CYCLES(SETTLE_CYCLES)
	) u_region (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.region_opt   (region_opt),
		.header_region(header_region),
		.region       (region),
		.region_set   (region_set)
	);

endmodule

// ==== bench/cart_glue_chk.sv ====
`timescale 1ns/1ps

module cart_glue_chk
	import cart_pkg::*;
(
	input logic      clk_sys,
	input logic      reset,
	input logic      load_active,
	input logic      work_ram_ce_n,
	input logic      cart_ram_ce_n,
	input logic      cart_rom_ce_n,
	input mem_addr_t mem_addr,
	input region_t   region,
	input logic      region_set
);

	// Only three region codes exist
	region_legal: assert property (@(posedge clk_sys) disable iff (reset)
		region != 2'd3)
		else $error("region holds the unused code 3");

	// Cart ROM access lands in the ROM window of the shared memory
	rom_window: assert property (@(posedge clk_sys) disable iff (reset)
		(!cart_rom_ce_n && !load_active && work_ram_ce_n && cart_ram_ce_n)
		|-> (mem_addr[23:22] == CART_ROM_BASE))
		else $error("cart ROM access routed outside the ROM window");

	// Settle strobe follows every region change
	settle_start: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(region) |-> region_set)
		else $error("region_set low right after a region change");

endmodule

bind cart_glue_top cart_glue_chk u_chk (.*);

// ==== bench/tb_cart_glue.sv ====
`timescale 1ns/1ps

module tb_cart_glue
	import cart_pkg::*;
();

	localparam int CLK_PERIOD  = 8;
	localparam int SETTLE      = 16;
	localparam int TEST_CYCLES = 30 + 40 + 60 + 60 + 90 + 70 + 30;  // Reset plus six tests
	localparam int TIMEOUT_NS  = 2 * TEST_CYCLES * CLK_PERIOD;

	logic       clk_sys = 1'b0;
	logic       reset;
	logic       load_active, load_is_cart, load_wr;
	load_addr_t load_addr;
	data_t      load_data;
	bus_addr_t  bus_va;
	data_t      bus_vdo;
	logic       bus_rnw, page_ce_n;
	logic       work_ram_ce_n, cart_ram_ce_n, cart_rom_ce_n;
	logic [1:0] region_opt;
	mem_addr_t  mem_addr;
	logic       cart_mode;
	region_t    region;
	logic       region_set;

	// Reference model state
	bank_t       ref_bank [BANK_COUNT];
	rom_mask_t   ref_mask;
	logic        ref_cart;
	logic [31:0] lfsr = 32'hcbab;
	logic        check_en;
	int          checks, errors, test_errs;

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	cart_glue_top #(
		.SETTLE_CYCLES(SETTLE)
	) DUT (.*);

	////////////////////////////////////////
	// Reference and random source
	////////////////////////////////////////

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};  // Taps 32 22 2 1
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic mem_addr_t route_ref();
		bus_addr_t rom;
		rom = {ref_bank[bus_va[21:19]], bus_va[18:1]} & {ref_mask, 12'hFFF};
		if (load_active)
			return load_is_cart ? {CART_ROM_BASE, load_addr[22:1]}
			                    : {BIOS_LOAD_BASE, load_addr[18:1]};
		else if (!work_ram_ce_n)
			return {WORK_RAM_BASE, bus_va[15:1]};
		else if (!cart_ram_ce_n)
			return {CART_RAM_BASE, bus_va[19:1]};
		else if (!cart_rom_ce_n)
			return {CART_ROM_BASE, rom[22:1]};
		return {BIOS_BASE, bus_va[16:1]};
	endfunction

	task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
		errors++;
		$display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
	endtask

	// Compare mid cycle, away from the drive edge
	always @(negedge clk_sys) begin
		if (check_en) begin
			checks++;
			if (mem_addr !== route_ref())
				value_error("mem_addr", {8'h00, route_ref()}, {8'h00, mem_addr});
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the tests did not finish in time");
		$display("Verification failed");
		$finish;
	end

	////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic start_load(input logic is_cart);
		next_cycle();
		load_active  = 1'b1;
		load_is_cart = is_cart;
		load_wr      = 1'b0;
		check_en     = 1'b0;
		for (int i = 0; i < BANK_COUNT; i++)
			ref_bank[i] = bank_t'(i);  // Download restores identity banking
	endtask

	task automatic load_word(input load_addr_t a, input data_t d);
		next_cycle();
		load_wr   = 1'b1;
		load_addr = a;
		load_data = d;
		check_en  = 1'b1;
		ref_cart  = load_is_cart;
		if (load_is_cart)
			ref_mask = (a == '0) ? '0 : (ref_mask | a[23:13]);
	endtask

	task automatic end_load();
		next_cycle();
		load_wr     = 1'b0;
		load_active = 1'b0;
		check_en    = 1'b0;
		checks++;
		if (cart_mode !== ref_cart)
			value_error("cart_mode", {31'd0, ref_cart}, {31'd0, cart_mode});
	endtask

	task automatic access(input bus_addr_t va, input logic wram_n, input logic cram_n,
	                      input logic crom_n);
		next_cycle();
		bus_va        = va;
		bus_rnw       = 1'b1;
		work_ram_ce_n = wram_n;
		cart_ram_ce_n = cram_n;
		cart_rom_ce_n = crom_n;
		check_en      = 1'b1;
	endtask

	task automatic page_write(input logic [2:0] idx, input bank_t val);
		next_cycle();
		check_en      = 1'b0;
		cart_rom_ce_n = 1'b1;
		bus_va        = {20'd0, idx};
		bus_vdo       = {11'd0, val};
		bus_rnw       = 1'b0;
		page_ce_n     = 1'b0;
		next_cycle();  // Falling edge seen on this clock
		page_ce_n = 1'b1;
		bus_rnw   = 1'b1;
		if (idx != 3'd0 && ref_mask[23:22] != 2'b00)
			ref_bank[idx] = val;
	endtask

	task automatic wait_settled();
		int guard;
		guard = 0;
		@(negedge clk_sys);
		while (region_set && guard < 4 * SETTLE) begin
			guard++;
			@(negedge clk_sys);
		end
		if (region_set) begin
			errors++;
			$display("region_set did not fall within %0d cycles", 4 * SETTLE);
		end
	endtask

	task automatic header_load(input logic [7:0] letter, input region_t exp);
		logic [31:0] r;
		r = rand_bits(16);
		start_load(1'b1);
		load_word('0, r[15:0]);
		load_word(HEADER_REGION_ADDR, {8'h00, letter});
		end_load();
		@(posedge clk_sys);  // Region follows the header one edge later
		@(negedge clk_sys);
		if (region !== exp)
			value_error("region", {30'd0, region_t'(exp)}, {30'd0, region});
		wait_settled();
	endtask

	// Change region_opt and count the strobe length
	task automatic settle_check(input logic [1:0] opt, input region_t exp);
		int n;
		next_cycle();
		region_opt = opt;
		@(posedge clk_sys);
		@(negedge clk_sys);
		if (region !== exp)
			value_error("region", {30'd0, region_t'(exp)}, {30'd0, region});
		n = 0;
		while (region_set && n < 4 * SETTLE) begin
			n++;
			@(negedge clk_sys);
		end
		if (n != SETTLE)
			value_error("region_set cycles", SETTLE, n);
	endtask

	task automatic end_test(input string name);
		$display("%s: %0d errors", name, errors - test_errs);
		test_errs = errors;
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		logic [31:0] r;
		logic [2:0]  idx;
		reset = 1'b1;
		{load_active, load_is_cart, load_wr} = 3'b000;
		load_addr = '0;
		load_data = '0;
		bus_va    = '0;
		bus_vdo   = '0;
		{bus_rnw, page_ce_n} = 2'b11;
		{work_ram_ce_n, cart_ram_ce_n, cart_rom_ce_n} = 3'b111;
		region_opt = 2'd0;
		ref_mask   = '0;
		ref_cart   = 1'b0;
		check_en   = 1'b0;
		checks = 0;
		errors = 0;
		test_errs = 0;
		for (int i = 0; i < BANK_COUNT; i++)
			ref_bank[i] = bank_t'(i);
		repeat (5) @(posedge clk_sys);
		#1 reset = 1'b0;
		wait_settled();  // Power-up settle time

		start_load(1'b1);
		load_word('0, 16'h0000);
		for (int i = 0; i < 12; i++) begin
			r = rand_bits(32);
			load_word({2'b00, r[22:1], 1'b0}, r[31:16]);
		end
		start_load(1'b0);  // BIOS image right behind
		for (int i = 0; i < 12; i++) begin
			r = rand_bits(32);
			load_word({r[24:1], 1'b0}, r[31:16]);
		end
		end_load();
		end_test("download routing");

		start_load(1'b1);
		load_word('0, 16'h0000);
		for (int i = 0; i < 12; i++) begin
			r = rand_bits(32);
			load_word({4'd0, r[20:1], 1'b0}, r[31:16]);  // Stays under 2 MB
		end
		end_load();
		for (int i = 0; i < 16; i++)
			access(bus_addr_t'(rand_bits(23)), 1'b1, 1'b1, 1'b0);
		for (int i = 0; i < 4; i++) begin
			r = rand_bits(8);
			page_write(r[2:0], r[7:3]);
		end
		for (int i = 0; i < 16; i++)
			access(bus_addr_t'(rand_bits(23)), 1'b1, 1'b1, 1'b0);
		end_test("small ROM");

		start_load(1'b1);
		load_word('0, 16'h0000);
		load_word(25'h7FFFFE, 16'hFFFF);  // Top of an 8 MB image
		for (int i = 0; i < 8; i++) begin
			r = rand_bits(32);
			load_word({2'b00, r[22:1], 1'b0}, r[31:16]);
		end
		end_load();
		for (int i = 0; i < 6; i++) begin
			r = rand_bits(26);
			idx = (r[2:0] == 3'd0) ? 3'd1 : r[2:0];
			page_write(idx, r[7:3]);
			access({2'b00, idx, r[25:8]}, 1'b1, 1'b1, 1'b0);
		end
		start_load(1'b0);
		for (int i = 0; i < 4; i++) begin
			r = rand_bits(32);
			load_word({r[24:1], 1'b0}, r[31:16]);
		end
		end_load();
		for (int i = 0; i < 16; i++)
			access(bus_addr_t'(rand_bits(23)), 1'b1, 1'b1, 1'b0);  // Identity again
		end_test("large ROM banking");

		header_load(8'h55, REGION_US);
		header_load(8'h45, REGION_EU);
		header_load(8'h4A, REGION_JP);
		end_test("header region");

		settle_check(2'd2, REGION_US);
		settle_check(2'd3, REGION_EU);
		settle_check(2'd1, REGION_JP);
		next_cycle();
		region_opt = 2'd0;
		end_test("override and settle");

		for (int i = 0; i < 24; i++) begin
			r = rand_bits(25);
			case (r[24:23])
				2'd0:    access(r[22:0], 1'b0, 1'b1, 1'b1);
				2'd1:    access(r[22:0], 1'b1, 1'b0, 1'b1);
				default: access(r[22:0], 1'b1, 1'b1, 1'b1);
			endcase
		end
		next_cycle();
		check_en = 1'b0;
		end_test("RAM and BIOS windows");

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// ==== compile.f ====
verilog/cart_pkg.sv
verilog/rom_header_sniff.sv
verilog/bank_regs.sv
verilog/mem_addr_route.sv
verilog/region_select.sv
verilog/cart_glue_top.sv
bench/cart_glue_chk.sv
bench/tb_cart_glue.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cartridge glue testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
	--top-module tb_cart_glue \
	-f compile.f \
	-o sim_cart_glue; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_cart_glue)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^Verification passed$"; then
	exit 0
fi

exit 1
